/* Bender.yml */
package:
  name: x68k_glue

sources:
  - verilog/x68k_glue_pkg.sv
  - verilog/core_config.sv
  - verilog/clock_enables.sv
  - verilog/reset_sequencer.sv
  - verilog/rom_loader_bridge.sv
  - verilog/activity_led.sv
  - verilog/mt32_info_select.sv
  - verilog/x68k_glue_top.sv
  - target: test
    files:
      - test/x68k_glue_sva.sv
      - test/tb_x68k_glue.sv

/* src.f */
verilog/x68k_glue_pkg.sv
verilog/core_config.sv
verilog/clock_enables.sv
verilog/reset_sequencer.sv
verilog/rom_loader_bridge.sv
verilog/activity_led.sv
verilog/mt32_info_select.sv
verilog/x68k_glue_top.sv
test/x68k_glue_sva.sv
test/tb_x68k_glue.sv

/* test/tb_x68k_glue.sv */
`timescale 1ns/10ps

module tb_x68k_glue
	import x68k_glue_pkg::*;
;

	localparam int CLK_PERIOD  = 100;
	localparam int TEST_CYCLES = 10 + 4 * 50 + 80 + 150 + 170 + 80 + 130 + 20;
	localparam int MARGIN      = 400;

	logic         clk_sys = 1'b0;
	logic         reset_delayed;
	logic         user_button;
	logic         ioctl_download;
	logic         ioctl_wr;
	logic         ldr_ack;
	logic         snd_clockmode;
	logic         mt32_newmode;
	status_t      status;
	drive_flags_t img_mounted;
	drive_flags_t sd_ack;
	mt32_mode_e   mt32_mode;
	logic [7:0]   mt32_rom;
	logic [7:0]   mt32_sf;
	clk_en_t      clk_en;
	core_cfg_t    cfg;
	drive_flags_t img_mounted_d;
	logic [1:0]   fdd_eject_d;
	logic         core_rstn;
	logic         ldr_wr;
	logic         ldr_aen;
	logic         hdd_active;
	logic         mt32_info_req;
	logic [3:0]   mt32_info_disp;

	integer seed = 32'h427e423d;
	int     strobe_cnt [6];
	int     test_errors;
	int     total_errors;
	int     tests_run;
	int     tests_failed;
	string  test_name;

	x68k_glue_top #(
		.MOUNT_HOLD    (64),
		.MOUNTED_TAIL  (16),
		.EJECT_HOLD    (20),
		.HDD_RESET_HOLD(30),
		.LED_HOLD      (25)
	) uut (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////
	// Reference model

	// Strobes per window, index 0 sys, 1 cep, 2 cen, 3 snd, 4 opm0, 5 opm1
	function automatic int expected_count(int idx, bit turbo, bit sndmode, int window);
		int period;
		case (idx)
			0: period = 4;
			1, 2: period = turbo ? 2 : 4;
			3: period = sndmode ? 10 : 5;
			4: period = 10;
			default: period = 20;
		endcase
		return window / period;
	endfunction

	// Returns {fdd_eject_d, img_mounted_d} for one floppy slot
	function automatic logic [1:0] floppy_flags(int mount_cnt, int eject_cnt);
		logic ejected;
		ejected = (eject_cnt != 0) || (mount_cnt >= 16);
		return {ejected, (mount_cnt != 0) && !ejected};
	endfunction

	function automatic logic [3:0] info_code(logic [7:0] mode, logic [7:0] rom,
		logic [7:0] sf);
		if (mode == 8'hA2)
			return 4'd1 + sf[2:0];
		if (mode == 8'hA1 && rom <= 8'd2)
			return 4'd9 + rom[3:0];
		return 4'd12;
	endfunction

	// Menu fields at their status word positions
	function automatic core_cfg_t cfg_fields(status_t st);
		core_cfg_t c;
		c.reset_req  = st[0];
		c.turbo      = st[32];
		c.nmi        = st[7];
		c.power      = st[8];
		c.fd_sync    = st[10:9];
		c.fd_eject   = st[12:11];
		c.sram_load  = st[13];
		c.sram_store = st[14];
		c.video_orig = st[33];
		c.info_mode  = info_mode_e'(st[42:41]);
		return c;
	endfunction

	////////////////////////////////////////////////////////////
	// Compare tasks
	task automatic check_clk_en(string what, clk_en_t exp, clk_en_t act);
		if (exp !== act) begin
			$display("[ERROR] %s %s: expected %b, actual %b", test_name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_cfg(string what, core_cfg_t exp, core_cfg_t act);
		if (exp !== act) begin
			$display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_flags(string what, drive_flags_t exp, drive_flags_t act);
		if (exp !== act) begin
			$display("[ERROR] %s %s: expected %b, actual %b", test_name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_info(string what, logic [3:0] exp, logic [3:0] act);
		if (exp !== act) begin
			$display("[ERROR] %s %s: expected %0d, actual %0d", test_name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
		if (exp !== act) begin
			$display("[ERROR] %s %s: expected %0d, actual %0d", test_name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic report_problem(string text);
		$display("%s: %s", test_name, text);
		test_errors++;
	endtask

	task automatic begin_test(string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests_run++;
		total_errors += test_errors;
		if (test_errors != 0) begin
			tests_failed++;
			$display("FAIL %s (%0d errors)", test_name, test_errors);
		end else begin
			$display("PASS %s", test_name);
		end
	endtask

	task automatic wait_cycles(int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic count_strobes(int window);
		for (int i = 0; i < 6; i++) begin
			strobe_cnt[i] = 0;
		end
		repeat (window) begin
			@(negedge clk_sys);
			strobe_cnt[0] += clk_en.sys_ce;
			strobe_cnt[1] += clk_en.mpu_cep;
			strobe_cnt[2] += clk_en.mpu_cen;
			strobe_cnt[3] += clk_en.snd_ce;
			strobe_cnt[4] += clk_en.opm_ce[0];
			strobe_cnt[5] += clk_en.opm_ce[1];
		end
	endtask

	task automatic check_window(bit turbo, bit sndmode);
		count_strobes(40);
		for (int i = 0; i < 6; i++) begin
			check_value($sformatf("strobe %0d count", i),
				expected_count(i, turbo, sndmode, 40), strobe_cnt[i]);
		end
	endtask

	// Cycles until sig equals level, -1 on timeout
	task automatic cycles_until(ref logic sig, input logic level, input int limit,
		output int n);
		n = 0;
		while (sig !== level && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (sig !== level)
			n = -1;
	endtask

	////////////////////////////////////////////////////////////
	// Watchdog
	initial begin
		#((TEST_CYCLES + MARGIN) * CLK_PERIOD);
		$display("Watchdog expired before the tests completed");
		$display("Test FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	initial begin
		int n;
		int mcnt;
		int ecnt;
		logic [1:0] fl;
		logic [7:0] mode_v;

		reset_delayed  = 1'b1;
		user_button    = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ldr_ack        = 1'b0;
		snd_clockmode  = 1'b0;
		mt32_newmode   = 1'b0;
		status         = '0;
		status[ST_RESET] = 1'b1;
		img_mounted    = '0;
		sd_ack         = '0;
		mt32_mode      = MODE_MUNT;
		mt32_rom       = '0;
		mt32_sf        = '0;
		tests_run      = 0;
		tests_failed   = 0;
		total_errors   = 0;

		begin_test("reset_values");
		wait_cycles(10);
		check_clk_en("clk_en", '0, clk_en);
		check_value("ldr_wr", 0, ldr_wr);
		check_value("ldr_aen", 0, ldr_aen);
		check_value("core_rstn", 0, core_rstn);
		check_value("hdd_active", 0, hdd_active);
		check_value("mt32_info_req", 0, mt32_info_req);
		reset_delayed = 1'b0;
		end_test();

		begin_test("clock_enables");
		wait_cycles(2);
		check_window(1'b0, 1'b0);
		snd_clockmode = 1'b1;
		wait_cycles(2);
		check_window(1'b0, 1'b1);
		status[ST_TURBO] = 1'b1;
		wait_cycles(10);
		check_window(1'b1, 1'b1);
		status[ST_TURBO] = 1'b0;
		wait_cycles(10);
		check_window(1'b0, 1'b1);
		end_test();

		begin_test("reset_release");
		check_value("core_rstn in menu reset", 0, core_rstn);
		status[ST_RESET] = 1'b0;
		wait_cycles(6);
		check_value("core_rstn before download", 0, core_rstn);
		// Menu reset held again while the download starts
		status[ST_RESET] = 1'b1;
		wait_cycles(2);
		ioctl_download = 1'b1;
		wait_cycles(6);
		check_value("core_rstn in menu reset during download", 0, core_rstn);
		status[ST_RESET] = 1'b0;
		cycles_until(core_rstn, 1'b1, 10, n);
		if (n < 0)
			report_problem("core_rstn did not rise after the menu reset was released");
		end_test();

		begin_test("loader_handshake");
		check_value("ldr_aen during download", 1, ldr_aen);
		for (int w = 0; w < 3; w++) begin
			ioctl_wr = 1'b1;
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
			check_value("ldr_wr after ioctl_wr", 1, ldr_wr);
			wait_cycles(2 + w);
			check_value("ldr_wr while waiting", 1, ldr_wr);
			ldr_ack = 1'b1;
			cycles_until(ldr_wr, 1'b0, 10, n);
			ldr_ack = 1'b0;
			if (n < 0)
				report_problem("ldr_wr did not fall after ldr_ack");
			else
				check_value("ack to ldr_wr fall", 2, n);
			wait_cycles(2);
		end
		ioctl_download = 1'b0;
		@(negedge clk_sys);
		// A second download no longer opens the loader
		ioctl_download = 1'b1;
		ioctl_wr = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		for (int k = 0; k < 4; k++) begin
			check_value("ldr_aen after download", 0, ldr_aen);
			check_value("ldr_wr after download", 0, ldr_wr);
			@(negedge clk_sys);
		end
		ioctl_download = 1'b0;
		end_test();

		begin_test("floppy_mount");
		img_mounted[0] = 1'b1;
		@(negedge clk_sys);
		img_mounted[0] = 1'b0;
		mcnt = 64;
		repeat (70) begin
			fl = floppy_flags(mcnt, 0);
			check_flags("img_mounted_d", {3'b000, fl[0]}, img_mounted_d);
			check_flags("fdd_eject_d", {2'b00, 1'b0, fl[1]}, {2'b00, fdd_eject_d});
			mcnt = (mcnt > 0) ? mcnt - 1 : 0;
			@(negedge clk_sys);
		end
		// Menu eject held over a fresh mount
		status[ST_FDEJECT] = 1'b1;
		img_mounted[0] = 1'b1;
		@(negedge clk_sys);
		img_mounted[0] = 1'b0;
		wait_cycles(60);
		mcnt = 4;
		ecnt = 20;
		fl = floppy_flags(mcnt, ecnt);
		check_flags("held eject img", {3'b000, fl[0]}, img_mounted_d);
		check_flags("held eject", {3'b000, fl[1]}, {2'b00, fdd_eject_d});
		status[ST_FDEJECT] = 1'b0;
		wait_cycles(30);
		check_flags("after eject", '0, {2'b00, fdd_eject_d});
		end_test();

		begin_test("hdd_reset");
		// Hard disk and SRAM image mounted together
		img_mounted[3:2] = 2'b11;
		@(negedge clk_sys);
		img_mounted[3:2] = 2'b00;
		check_flags("img_mounted_d after mount", 4'b1100, img_mounted_d);
		cycles_until(core_rstn, 1'b0, 10, n);
		if (n < 0) begin
			report_problem("core_rstn did not fall after the hard disk mount");
		end else begin
			cycles_until(core_rstn, 1'b1, 100, n);
			if (n < 0)
				report_problem("core_rstn stayed low after the hard disk mount");
			else if (n < 27 || n > 33)
				check_value("core_rstn low cycles", 30, n);
			check_flags("img_mounted_d during hold", 4'b1100, img_mounted_d);
		end
		end_test();

		begin_test("mt32_info");
		status[ST_MT32_INFO +: 2] = INFO_ON_CHANGE;
		for (int r = 0; r < 24; r++) begin
			case ($random(seed) & 3)
				0: mode_v = 8'hA1;
				1: mode_v = 8'hA2;
				default: mode_v = $random(seed);
			endcase
			mt32_mode = mt32_mode_e'(mode_v);
			mt32_rom  = $random(seed) & 8'h03;
			mt32_sf   = $random(seed);
			@(negedge clk_sys);
			check_info("mt32_info_disp", info_code(mode_v, mt32_rom, mt32_sf),
				mt32_info_disp);
		end
		mt32_newmode = ~mt32_newmode;
		@(negedge clk_sys);
		check_value("info_req on toggle", 1, mt32_info_req);
		@(negedge clk_sys);
		check_value("info_req one cycle", 0, mt32_info_req);
		status[ST_MT32_INFO +: 2] = INFO_OFF;
		wait_cycles(2);
		mt32_newmode = ~mt32_newmode;
		repeat (2) begin
			@(negedge clk_sys);
			check_value("info_req when off", 0, mt32_info_req);
		end
		end_test();

		begin_test("hdd_led");
		sd_ack[HDD_SLOT] = 1'b1;
		@(negedge clk_sys);
		sd_ack[HDD_SLOT] = 1'b0;
		cycles_until(hdd_active, 1'b1, 5, n);
		if (n < 0) begin
			report_problem("hdd_active did not rise after sd_ack");
		end else begin
			cycles_until(hdd_active, 1'b0, 100, n);
			if (n < 0)
				report_problem("hdd_active did not fall");
			else if (n < 23 || n > 27)
				check_value("hdd_active high cycles", 25, n);
		end
		end_test();

		begin_test("config_decode");
		for (int r = 0; r < 8; r++) begin
			status = {$random(seed), $random(seed)};
			@(negedge clk_sys);
			check_cfg("cfg", cfg_fields(status), cfg);
		end
		end_test();

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
			total_errors);
		if (total_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* test/x68k_glue_sva.sv */
`timescale 1ns/10ps

module x68k_glue_sva
	import x68k_glue_pkg::*;
(
	input logic    clk_sys,
	input logic    reset_delayed,
	input clk_en_t clk_en,
	input logic    ldr_wr,
	input logic    ldr_done
);

	////////////////////////////////////////////////////////////
	// Clock enable strobes
	a_sys_width: assert property (@(posedge clk_sys) disable iff (reset_delayed)
		clk_en.sys_ce |=> !clk_en.sys_ce)
		else $error("sys_ce wider than one cycle");

	a_snd_width: assert property (@(posedge clk_sys) disable iff (reset_delayed)
		clk_en.snd_ce |=> !clk_en.snd_ce)
		else $error("snd_ce wider than one cycle");

	a_opm_width: assert property (@(posedge clk_sys) disable iff (reset_delayed)
		|clk_en.opm_ce |=> !(|clk_en.opm_ce))
		else $error("opm_ce wider than one cycle");

	a_mpu_width: assert property (@(posedge clk_sys) disable iff (reset_delayed)
		(clk_en.mpu_cep |=> !clk_en.mpu_cep) and (clk_en.mpu_cen |=> !clk_en.mpu_cen))
		else $error("mpu phase strobe wider than one cycle");

	a_mpu_phases: assert property (@(posedge clk_sys) disable iff (reset_delayed)
		!(clk_en.mpu_cep && clk_en.mpu_cen))
		else $error("mpu_cep and mpu_cen high together");

	// Loader request after the download has ended
	a_ldr_after_done: assert property (@(posedge clk_sys) disable iff (reset_delayed)
		$rose(ldr_wr) |-> !$past(ldr_done))
		else $error("ldr_wr rose while ldr_done was set");

endmodule

bind x68k_glue_top x68k_glue_sva u_sva (
	.clk_sys      (clk_sys),
	.reset_delayed(reset_delayed),
	.clk_en       (clk_en),
	.ldr_wr       (ldr_wr),
	.ldr_done     (u_rom_loader_bridge.ldr_done)
);

/* verilog/activity_led.sv */
`timescale 1ns/10ps

module activity_led #(
	parameter int LED_HOLD = 4500000
) (
	input  logic clk_sys,
	input  logic reset_delayed,
	input  logic in,
	output logic out
);

	localparam int CW = $clog2(LED_HOLD + 1);

	logic [CW-1:0] counter;

	// Each access pulse restarts the visible on time
	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			counter <= '0;
			out     <= 1'b0;
		end else begin
			out <= (counter != '0);
			if (in) begin
				counter <= CW'(LED_HOLD);
			end else if (counter != '0) begin
				counter <= counter - 1'b1;
			end
		end
	end

endmodule

/* verilog/clock_enables.sv */
`timescale 1ns/10ps

module clock_enables
	import x68k_glue_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_delayed,
	input  logic      snd_clockmode,
	input  core_cfg_t cfg,
	output clk_en_t   clk_en
);

	localparam int SYS_W  = $clog2(SYS_DIV);
	localparam int FAST_W = $clog2(SND_DIV_FAST);
	localparam int SLOW_W = $clog2(SND_DIV_SLOW);
	localparam int OPM_W  = $clog2(OPM_DIV);

	localparam logic [SYS_W-1:0]  SYS_LAST  = SYS_W'(SYS_DIV - 1);
	localparam logic [FAST_W-1:0] FAST_LAST = FAST_W'(SND_DIV_FAST - 1);
	localparam logic [SLOW_W-1:0] SLOW_LAST = SLOW_W'(SND_DIV_SLOW - 1);
	localparam logic [OPM_W-1:0]  OPM_LAST  = OPM_W'(OPM_DIV - 1);

	logic [SYS_W-1:0]  div_sys;
	logic [FAST_W-1:0] div_snd;
	logic [SLOW_W-1:0] div_snd2;
	logic [OPM_W-1:0]  div_opm;
	logic              turbo;

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			div_sys  <= '0;
			div_snd  <= '0;
			div_snd2 <= '0;
			div_opm  <= '0;
			turbo    <= 1'b0;
			clk_en   <= '0;
		end else begin
			div_sys <= div_sys + 1'b1;

			// Fast sound divider stays aligned to the slow one
			if (div_snd == FAST_LAST || div_snd2 == SLOW_LAST) begin
				div_snd <= '0;
			end else begin
				div_snd <= div_snd + 1'b1;
			end
			div_snd2 <= (div_snd2 == SLOW_LAST) ? '0 : div_snd2 + 1'b1;
			div_opm  <= (div_opm == OPM_LAST) ? '0 : div_opm + 1'b1;

			// Speed change only takes effect on a CPU period boundary
			if (div_sys == SYS_LAST) begin
				turbo <= cfg.turbo;
			end

			clk_en.sys_ce    <= (div_sys == SYS_LAST);
			clk_en.opm_ce[0] <= (div_snd2 == SLOW_LAST);
			clk_en.opm_ce[1] <= (div_opm == OPM_LAST);
			clk_en.snd_ce    <= snd_clockmode ? (div_snd2 == SLOW_LAST) : (div_snd == FAST_LAST);

			// Normal mode spaces the two CPU phases half a period apart
			clk_en.mpu_cep <= turbo ? div_sys[0] : (div_sys[1] & div_sys[0]);
			clk_en.mpu_cen <= turbo ? ~div_sys[0] : (~div_sys[1] & div_sys[0]);
		end
	end

endmodule

/* verilog/core_config.sv */
`timescale 1ns/10ps

module core_config
	import x68k_glue_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_delayed,
	input  status_t   status,
	output core_cfg_t cfg,
	output logic      init_done
);

	logic reset_req_q;

	////////////////////////////////////////////////////////////
	// Menu fields, one cycle behind the status word
	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			cfg <= '0;
		end else begin
			cfg.reset_req  <= status[ST_RESET];
			cfg.turbo      <= status[ST_TURBO];
			cfg.nmi        <= status[ST_NMI];
			cfg.power      <= status[ST_POWER];
			cfg.fd_sync    <= status[ST_FDSYNC +: 2];
			cfg.fd_eject   <= status[ST_FDEJECT +: 2];
			cfg.sram_load  <= status[ST_SRAMLD];
			cfg.sram_store <= status[ST_SRAMST];
			cfg.video_orig <= status[ST_VIDHZ];
			// Two option bits select how the synth info is shown
			cfg.info_mode  <= info_mode_e'(status[ST_MT32_INFO +: 2]);
		end
	end

	////////////////////////////////////////////////////////////
	// The core may leave reset only after the menu reset
	// has been released once
	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			reset_req_q <= 1'b0;
			init_done   <= 1'b0;
		end else begin
			reset_req_q <= cfg.reset_req;
			if (reset_req_q && !cfg.reset_req) begin
				init_done <= 1'b1;
			end
		end
	end

endmodule

/* verilog/mt32_info_select.sv */
`timescale 1ns/10ps

module mt32_info_select
	import x68k_glue_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset_delayed,
	input  core_cfg_t  cfg,
	input  logic       mt32_newmode,
	input  mt32_mode_e mt32_mode,
	input  logic [7:0] mt32_rom,
	input  logic [7:0] mt32_sf,
	output logic       mt32_info_req,
	output logic [3:0] mt32_info_disp
);

	logic newmode_q;

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			newmode_q     <= 1'b0;
			mt32_info_req <= 1'b0;
		end else begin
			newmode_q     <= mt32_newmode;
			// Synth flips newmode on every mode change
			mt32_info_req <= (newmode_q ^ mt32_newmode) && (cfg.info_mode == INFO_ON_CHANGE);
		end
	end

	// Message codes, 1..8 soundfonts, 9..11 Munt ROMs, 12 unknown
	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			mt32_info_disp <= '0;
		end else if (mt32_mode == MODE_FLUID) begin
			mt32_info_disp <= 4'd1 + {1'b0, mt32_sf[2:0]};
		end else if (mt32_mode == MODE_MUNT && mt32_rom < 8'd3) begin
			mt32_info_disp <= 4'd9 + mt32_rom[3:0];
		end else begin
			mt32_info_disp <= 4'd12;
		end
	end

endmodule

/* verilog/reset_sequencer.sv */
`timescale 1ns/10ps

module reset_sequencer
	import x68k_glue_pkg::*;
#(
	parameter int MOUNT_HOLD     = 16777215,
	parameter int MOUNTED_TAIL   = 65536,
	parameter int EJECT_HOLD     = 65535,
	parameter int HDD_RESET_HOLD = 65535
) (
	input  logic         clk_sys,
	input  logic         reset_delayed,
	input  core_cfg_t    cfg,
	input  logic         init_done,
	input  logic         user_button,
	input  drive_flags_t img_mounted,
	input  logic         rom_loaded,
	output drive_flags_t img_mounted_d,
	output logic [1:0]   fdd_eject_d,
	output logic         core_rstn
);

	localparam int MW = $clog2(MOUNT_HOLD + 1);
	localparam int EW = $clog2(EJECT_HOLD + 1);
	localparam int HW = $clog2(HDD_RESET_HOLD + 1);

	logic [MW-1:0] mount_count [4];
	logic [EW-1:0] eject_count [2];
	logic [HW-1:0] hdd_count;
	logic          hdd_mounted_q;
	logic          sys_reset;

	////////////////////////////////////////////////////////////
	// Hold counters for every image slot
	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			for (int i = 0; i < 4; i++) begin
				mount_count[i] <= '0;
			end
			for (int i = 0; i < 2; i++) begin
				eject_count[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 4; i++) begin
				if (img_mounted[i]) begin
					mount_count[i] <= MW'(MOUNT_HOLD);
				end else if (mount_count[i] != '0) begin
					mount_count[i] <= mount_count[i] - 1'b1;
				end
			end
			// A menu eject keeps reloading while the bit is held
			for (int i = 0; i < 2; i++) begin
				if (cfg.fd_eject[i]) begin
					eject_count[i] <= EW'(EJECT_HOLD);
				end else if (eject_count[i] != '0) begin
					eject_count[i] <= eject_count[i] - 1'b1;
				end
			end
		end
	end

	// Floppy shows as ejected first, then as mounted for the tail
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			fdd_eject_d[i]   = (eject_count[i] != '0) || (mount_count[i] >= MW'(MOUNTED_TAIL));
			img_mounted_d[i] = (mount_count[i] != '0) && !fdd_eject_d[i];
		end
		img_mounted_d[2] = (mount_count[2] != '0);
		img_mounted_d[3] = (mount_count[3] != '0);
	end

	////////////////////////////////////////////////////////////
	// Core reset, stretched after a hard disk mount
	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			hdd_mounted_q <= 1'b0;
			hdd_count     <= '0;
			sys_reset     <= 1'b1;
		end else begin
			hdd_mounted_q <= img_mounted[HDD_SLOT];
			if (img_mounted[HDD_SLOT] && !hdd_mounted_q) begin
				hdd_count <= HW'(HDD_RESET_HOLD);
			end else if (hdd_count != '0) begin
				hdd_count <= hdd_count - 1'b1;
			end
			sys_reset <= user_button | cfg.reset_req | ~init_done | (hdd_count != '0);
		end
	end

	// Nothing runs before the first ROM download has started
	assign core_rstn = rom_loaded & ~sys_reset;

endmodule

/* verilog/rom_loader_bridge.sv */
`timescale 1ns/10ps

module rom_loader_bridge (
	input  logic clk_sys,
	input  logic reset_delayed,
	input  logic ioctl_download,
	input  logic ioctl_wr,
	input  logic ldr_ack,
	output logic ldr_wr,
	output logic ldr_aen,
	output logic rom_loaded
);

	logic ldr_done;
	logic download_q;
	logic ack_q;
	logic ack_qq;

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			download_q <= 1'b0;
			ack_q      <= 1'b0;
			ack_qq     <= 1'b0;
			ldr_wr     <= 1'b0;
			ldr_done   <= 1'b0;
			rom_loaded <= 1'b0;
		end else begin
			download_q <= ioctl_download;
			// Ack comes from the core side, sampled before edge detection
			ack_q      <= ldr_ack;
			ack_qq     <= ack_q;

			if (ack_q && !ack_qq && ldr_wr) begin
				ldr_wr <= 1'b0;
			end
			// New write wins over a same-cycle ack
			if (ioctl_wr && !ldr_done) begin
				ldr_wr <= 1'b1;
			end

			if (download_q && !ioctl_download) begin
				ldr_done <= 1'b1;
			end
			if (!download_q && ioctl_download) begin
				rom_loaded <= 1'b1;
			end
		end
	end

	assign ldr_aen = ioctl_download & ~ldr_done;

endmodule

/* verilog/x68k_glue_pkg.sv */
package x68k_glue_pkg;

	// Menu status word as delivered by the host framework
	typedef logic [63:0] status_t;

	// One flag per image slot, 0..1 floppies, 2 hard disk, 3 SRAM image
	typedef logic [3:0] drive_flags_t;

	typedef enum logic [1:0] {
		INFO_OFF       = 2'd0,
		INFO_ON_CHANGE = 2'd1,
		INFO_LCD_ON    = 2'd2,
		INFO_LCD_AUTO  = 2'd3
	} info_mode_e;

	typedef enum logic [7:0] {
		MODE_MUNT  = 8'hA1,
		MODE_FLUID = 8'hA2
	} mt32_mode_e;

	typedef struct packed {
		logic       reset_req;
		logic       turbo;
		logic       nmi;
		logic       power;
		logic [1:0] fd_sync;
		logic [1:0] fd_eject;
		logic       sram_load;
		logic       sram_store;
		logic       video_orig;
		info_mode_e info_mode;
	} core_cfg_t;

	typedef struct packed {
		logic       sys_ce;
		logic       mpu_cep;
		logic       mpu_cen;
		logic       snd_ce;
		logic [1:0] opm_ce;
	} clk_en_t;

	////////////////////////////////////////////////////////////
	// Status word bit positions
	localparam int ST_RESET     = 0;
	localparam int ST_NMI       = 7;
	localparam int ST_POWER     = 8;
	localparam int ST_FDSYNC    = 9;
	localparam int ST_FDEJECT   = 11;
	localparam int ST_SRAMLD    = 13;
	localparam int ST_SRAMST    = 14;
	localparam int ST_MT32_INFO = 41;
	localparam int ST_TURBO     = 32;
	localparam int ST_VIDHZ     = 33;

	// Clock enable dividers, in clk_sys cycles
	localparam int SYS_DIV      = 4;
	localparam int SND_DIV_FAST = 5;
	localparam int SND_DIV_SLOW = 10;
	localparam int OPM_DIV      = 20;

	localparam int HDD_SLOT = 2;

endpackage

/* verilog/x68k_glue_top.sv */
`timescale 1ns/10ps

module x68k_glue_top
	import x68k_glue_pkg::*;
#(
	parameter int MOUNT_HOLD     = 16777215,
	parameter int MOUNTED_TAIL   = 65536,
	parameter int EJECT_HOLD     = 65535,
	parameter int HDD_RESET_HOLD = 65535,
	parameter int LED_HOLD       = 4500000
) (
	input  logic         clk_sys,
	input  logic         reset_delayed,
	input  logic         user_button,
	input  logic         ioctl_download,
	input  logic         ioctl_wr,
	input  logic         ldr_ack,
	input  logic         snd_clockmode,
	input  logic         mt32_newmode,
	input  status_t      status,
	input  drive_flags_t img_mounted,
	input  drive_flags_t sd_ack,
	input  mt32_mode_e   mt32_mode,
	input  logic [7:0]   mt32_rom,
	input  logic [7:0]   mt32_sf,
	output clk_en_t      clk_en,
	output core_cfg_t    cfg,
	output drive_flags_t img_mounted_d,
	output logic [1:0]   fdd_eject_d,
	output logic         core_rstn,
	output logic         ldr_wr,
	output logic         ldr_aen,
	output logic         hdd_active,
	output logic         mt32_info_req,
	output logic [3:0]   mt32_info_disp
);

	logic init_done;
	logic rom_loaded;

	////////////////////////////////////////////////////////////
	// Configuration and clocking
	core_config u_core_config (
		.clk_sys      (clk_sys),
		.reset_delayed(reset_delayed),
		.status       (status),
		.cfg          (cfg),
		.init_done    (init_done)
	);

	clock_enables u_clock_enables (
		.clk_sys      (clk_sys),
		.reset_delayed(reset_delayed),
		.snd_clockmode(snd_clockmode),
		.cfg          (cfg),
		.clk_en       (clk_en)
	);

	////////////////////////////////////////////////////////////
	// Loader, reset and disk status
	rom_loader_bridge u_rom_loader_bridge (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.ioctl_download(ioctl_download),
		.ioctl_wr      (ioctl_wr),
		.ldr_ack       (ldr_ack),
		.ldr_wr        (ldr_wr),
		.ldr_aen       (ldr_aen),
		.rom_loaded    (rom_loaded)
	);

	reset_sequencer #(
		.MOUNT_HOLD    (MOUNT_HOLD),
		.MOUNTED_TAIL  (MOUNTED_TAIL),
		.EJECT_HOLD    (EJECT_HOLD),
		.HDD_RESET_HOLD(HDD_RESET_HOLD)
	) u_reset_sequencer (
		.clk_sys      (clk_sys),
		.reset_delayed(reset_delayed),
		.cfg          (cfg),
		.init_done    (init_done),
		.user_button  (user_button),
		.img_mounted  (img_mounted),
		.rom_loaded   (rom_loaded),
		.img_mounted_d(img_mounted_d),
		.fdd_eject_d  (fdd_eject_d),
		.core_rstn    (core_rstn)
	);

	// Hard disk activity only
	activity_led #(
		.LED_HOLD(LED_HOLD)
	) hdd_led (
		.clk_sys      (clk_sys),
		.reset_delayed(reset_delayed),
		.in           (sd_ack[HDD_SLOT]),
		.out          (hdd_active)
	);

	mt32_info_select u_mt32_info_select (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.cfg           (cfg),
		.mt32_newmode  (mt32_newmode),
		.mt32_mode     (mt32_mode),
		.mt32_rom      (mt32_rom),
		.mt32_sf       (mt32_sf),
		.mt32_info_req (mt32_info_req),
		.mt32_info_disp(mt32_info_disp)
	);

endmodule
